// File: Bender.yml
package:
  name: sprite_video

export_include_dirs:
  - .

sources:
  - tc_pkg.sv
  - dp_table.sv
  - rom_loader.sv
  - sprite_list_copy.sv
  - sprite_line_render.sv
  - pixel_mixer.sv
  - sprite_video_top.sv
  - target: test
    files:
      - tb_top.sv

// File: dp_table.sv
/*
 * Simple dual-port table, one write port and one registered read port.
 * Holds the sprite list and the sprite line buffer.
 */
`default_nettype none
`timescale 1ns/1ps

module dp_table #(
    parameter int  DEPTH     = 256,
    parameter type payload_t = logic [7:0]
) (
    input  wire                      clk_sys,
    input  wire                      wr,
    input  wire [$clog2(DEPTH)-1:0]  wr_addr,
    input  wire payload_t            wr_data,
    input  wire [$clog2(DEPTH)-1:0]  rd_addr,
    output payload_t                 rd_data
);

    payload_t mem [DEPTH];

    // read data follows the address by one cycle
    always_ff @(posedge clk_sys) begin
        if (wr) begin
            mem[wr_addr] <= wr_data;
        end
        rd_data <= mem[rd_addr];
    end

endmodule

`default_nettype wire

// File: pixel_mixer.sv
/*
 * Priority mixer and palette. Three ce_pix stages pick foreground, sprite
 * or background and look the result up in the RGB PROMs.
 */
`default_nettype none
`timescale 1ns/1ps

module pixel_mixer (
    input  wire                    clk_sys,
    input  wire                    reset,
    input  wire                    ce_pix,
    input  wire [24:0]             dl_addr,
    input  wire [7:0]              dl_data,
    input  wire                    prom_r_wr,
    input  wire                    prom_g_wr,
    input  wire                    prom_b_wr,
    input  wire                    prom_s_wr,
    input  wire [3:0]              fg_pix,
    input  wire tc_pkg::pal_idx_t  bg_pix,
    input  wire                    bg_off,
    input  wire tc_pkg::spr_pix_t  spr_pix,
    output tc_pkg::rgb_t           rgb
);

    import tc_pkg::*;

    logic [3:0] prom_r [256];
    logic [3:0] prom_g [256];
    logic [3:0] prom_b [256];
    logic [3:0] prom_s [256];
    spr_pix_t   a_spr;
    logic [3:0] a_fg;
    pal_idx_t   a_bg;
    logic       a_bg_off;
    logic [1:0] spr_bank;
    pal_idx_t   spr_idx;
    pal_idx_t   b_idx;

    always_ff @(posedge clk_sys) begin
        if (prom_r_wr) begin
            prom_r[dl_addr[7:0]] <= dl_data[3:0];
        end
        if (prom_g_wr) begin
            prom_g[dl_addr[7:0]] <= dl_data[3:0];
        end
        if (prom_b_wr) begin
            prom_b[dl_addr[7:0]] <= dl_data[3:0];
        end
        if (prom_s_wr) begin
            prom_s[dl_addr[7:0]] <= dl_data[3:0];
        end
    end

    // pen bit 3 picks the upper bank pair
    assign spr_bank = a_spr.pen[3] ? a_spr.bank[3:2] : a_spr.bank[1:0];
    assign spr_idx  = {2'b10, spr_bank, prom_s[{a_spr.colour, a_spr.pen}]};

    // ==============================
    // stage A latch, stage B priority
    // ==============================
    always_ff @(posedge clk_sys) begin
        if (ce_pix) begin
            a_spr    <= spr_pix;
            a_fg     <= fg_pix;
            a_bg     <= bg_pix;
            a_bg_off <= bg_off;
            if (a_fg < 4'd15) begin
                b_idx <= {4'b0000, a_fg};
            end else if ((a_spr == '0) && !a_bg_off) begin
                b_idx <= a_bg;
            end else begin
                b_idx <= spr_idx;
            end
        end
    end

    // stage C palette
    always_ff @(posedge clk_sys) begin
        if (reset) begin
            rgb <= '0;
        end else if (ce_pix) begin
            rgb <= '{r: prom_r[b_idx], g: prom_g[b_idx], b: prom_b[b_idx]};
        end
    end

endmodule

`default_nettype wire

// File: rom_loader.sv
/*
 * Download decoder. Turns the download strobe into write strobes for the
 * sprite graphics ROM and the five colour PROMs, and flags a running ROM load.
 */
`default_nettype none
`timescale 1ns/1ps
`include "tc_params.svh"

module rom_loader (
    input  wire        clk_sys,
    input  wire        dl_active,
    input  wire [7:0]  dl_index,
    input  wire        dl_wr,
    input  wire [24:0] dl_addr,
    output logic       busy,
    output logic       gfx_wr,
    output logic       prom_r_wr,
    output logic       prom_g_wr,
    output logic       prom_b_wr,
    output logic       prom_s_wr,
    output logic       prom_u_wr
);

    logic rom_dl;
    logic rom_wr;

    // each PROM region is 256 bytes
    function automatic logic in_prom(input logic [24:0] addr, input logic [24:0] base);
        return (addr >= base) && (addr < base + 25'h100);
    endfunction

    assign rom_dl = dl_active && (dl_index == `TC_ROM_INDEX);
    assign rom_wr = rom_dl && dl_wr;

    assign gfx_wr    = rom_wr && (dl_addr >= `TC_GFX_BASE) && (dl_addr <= `TC_GFX_END);
    assign prom_r_wr = rom_wr && in_prom(dl_addr, `TC_PROM_R);
    assign prom_g_wr = rom_wr && in_prom(dl_addr, `TC_PROM_G);
    assign prom_b_wr = rom_wr && in_prom(dl_addr, `TC_PROM_B);
    assign prom_s_wr = rom_wr && in_prom(dl_addr, `TC_PROM_S);
    assign prom_u_wr = rom_wr && in_prom(dl_addr, `TC_PROM_U);

    // renderer stays idle while ROM data is half loaded
    always_ff @(posedge clk_sys) begin
        busy <= rom_dl;
    end

endmodule

`default_nettype wire

// File: sprite_line_render.sv
/*
 * Sprite line renderer. In the horizontal blank it clears the line buffer
 * and draws every sprite that crosses the next line, in list order.
 */
`default_nettype none
`timescale 1ns/1ps
`include "tc_params.svh"

module sprite_line_render (
    input  wire                      clk_sys,
    input  wire                      reset,
    input  wire                      busy,
    input  wire [8:0]                hcount,
    input  wire [8:0]                vcount,
    input  wire [24:0]               dl_addr,
    input  wire [7:0]                dl_data,
    input  wire                      gfx_wr,
    input  wire                      prom_u_wr,
    output logic [5:0]               list_addr,
    input  wire tc_pkg::spr_attr_t   list_data,
    output logic                     line_wr,
    output logic [7:0]               line_addr,
    output tc_pkg::spr_pix_t         line_data
);

    import tc_pkg::*;

    typedef enum logic [2:0] {
        S_IDLE,
        S_CLEAR,
        S_FETCH,
        S_TEST,
        S_DRAW,
        S_NEXT,
        S_WAIT
    } state_t;

    logic [7:0]  gfx_rom [65536];
    logic [3:0]  prom_u [256];
    state_t      state;
    spr_attr_t   attr;
    logic [7:0]  line_y;
    logic [7:0]  cnt;
    logic        phase;
    logic [5:0]  idx;
    logic [3:0]  ofs;
    logic [3:0]  row;
    logic [3:0]  fx;
    logic [3:0]  fy;
    logic [15:0] gfx_addr;
    logic [7:0]  gfx_q;
    logic [3:0]  pix_pen;
    logic [8:0]  pos;
    logic        hit;

    // ==============================
    // graphics lookup
    // ==============================
    assign ofs      = cnt[3:0];
    assign row      = 4'(line_y - attr.y);
    assign fx       = attr.flip_x ? 4'd15 - ofs : ofs;
    assign fy       = attr.flip_y ? 4'd15 - row : row;
    assign gfx_addr = {fx[1], attr.tile, fy, fx[3:2]};
    assign pix_pen  = fx[0] ? gfx_q[7:4] : gfx_q[3:0];
    assign pos      = attr.x + 9'(ofs);
    assign list_addr = idx;

    // sprite crosses the line and starts on screen
    assign hit = ({1'b0, line_y} >= {1'b0, list_data.y})
              && ({1'b0, line_y} < {1'b0, list_data.y} + 9'(`TC_SPR_SIZE))
              && (list_data.x < 9'(`TC_LINE_W));

    always_ff @(posedge clk_sys) begin
        if (gfx_wr) begin
            gfx_rom[dl_addr[15:0]] <= dl_data;
        end
        if (prom_u_wr) begin
            prom_u[dl_addr[7:0]] <= dl_data[3:0];
        end
        gfx_q <= gfx_rom[gfx_addr];
    end

    // clear writes zero, draw writes opaque pens that land on screen
    always_comb begin
        line_wr   = 1'b0;
        line_addr = cnt;
        line_data = '0;
        if (state == S_CLEAR) begin
            line_wr = 1'b1;
        end else if (state == S_DRAW) begin
            line_addr = pos[7:0];
            line_data = '{bank: prom_u[attr.tile[8:1]], colour: attr.colour, pen: pix_pen};
            line_wr   = phase && (pix_pen != 4'd0) && (pos < 9'(`TC_LINE_W));
        end
    end

    // ==============================
    // line FSM
    // ==============================
    always_ff @(posedge clk_sys) begin
        if (reset || busy) begin
            state <= S_IDLE;
            phase <= 1'b0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (hcount >= 9'(`TC_LINE_W)) begin
                        line_y <= 8'(vcount + 9'd1);
                        cnt    <= '0;
                        state  <= S_CLEAR;
                    end
                end
                S_CLEAR: begin
                    cnt <= cnt + 8'd1;
                    if (cnt == 8'(`TC_LINE_W - 1)) begin
                        idx   <= '0;
                        state <= S_FETCH;
                    end
                end
                S_FETCH: begin
                    state <= S_TEST;
                end
                S_TEST: begin
                    attr  <= list_data;
                    cnt   <= '0;
                    phase <= 1'b0;
                    state <= hit ? S_DRAW : S_NEXT;
                end
                S_DRAW: begin
                    // phase 0 addresses the ROM, phase 1 writes the pixel
                    phase <= !phase;
                    if (phase) begin
                        cnt <= cnt + 8'd1;
                        if (ofs == 4'(`TC_SPR_SIZE - 1)) begin
                            state <= S_NEXT;
                        end
                    end
                end
                S_NEXT: begin
                    idx   <= idx + 6'd1;
                    state <= (idx == 6'(`TC_SPRITES - 1)) ? S_WAIT : S_FETCH;
                end
                S_WAIT: begin
                    if (hcount == 9'd0) begin
                        state <= S_IDLE;
                    end
                end
                default: begin
                    state <= S_IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: sprite_list_copy.sv
/*
 * CPU sprite RAM and the vblank copy engine. On each vblank rise the 64
 * four-byte entries are decoded and written into the private sprite list.
 */
`default_nettype none
`timescale 1ns/1ps
`include "tc_params.svh"

module sprite_list_copy (
    input  wire               clk_sys,
    input  wire               reset,
    input  wire               spr_wr,
    input  wire [7:0]         spr_addr,
    input  wire [7:0]         spr_data,
    input  wire               vblank,
    output logic              list_wr,
    output logic [5:0]        list_addr,
    output tc_pkg::spr_attr_t list_data
);

    logic [7:0] spr_ram [256];
    logic [7:0] rd_byte;
    logic       vblank_q;
    logic       copying;
    logic [2:0] step;
    logic [5:0] entry;

    assign list_addr = entry;

    // CPU writes land at once, the sequencer reads byte {entry, step}
    always_ff @(posedge clk_sys) begin
        if (spr_wr) begin
            spr_ram[spr_addr] <= spr_data;
        end
        rd_byte <= spr_ram[{entry, step[1:0]}];
    end

    // ==============================
    // copy sequencer, 7 cycles per entry
    // ==============================
    always_ff @(posedge clk_sys) begin
        if (reset) begin
            vblank_q <= 1'b0;
            copying  <= 1'b0;
            step     <= '0;
            entry    <= '0;
            list_wr  <= 1'b0;
        end else begin
            vblank_q <= vblank;
            list_wr  <= 1'b0;
            if (vblank && !vblank_q) begin
                // a new edge restarts from entry 0
                copying <= 1'b1;
                step    <= '0;
                entry   <= '0;
            end else if (copying) begin
                step <= step + 3'd1;
                case (step)
                    3'd5: begin
                        list_wr <= 1'b1;
                    end
                    3'd6: begin
                        step <= '0;
                        if (entry == 6'(`TC_SPRITES - 1)) begin
                            copying <= 1'b0;
                        end else begin
                            entry <= entry + 6'd1;
                        end
                    end
                    default: begin
                    end
                endcase
            end
        end
    end

    // field decode, byte k shows up at step k+1
    always_ff @(posedge clk_sys) begin
        case (step)
            3'd1: begin
                list_data.y <= `TC_Y_BASE - rd_byte;
            end
            3'd2: begin
                list_data.tile[7:0] <= rd_byte;
            end
            3'd3: begin
                // x high bit parked here until byte 3 arrives
                list_data.x[8]    <= rd_byte[0];
                list_data.tile[8] <= rd_byte[1];
                list_data.flip_x  <= rd_byte[2];
                list_data.flip_y  <= rd_byte[3];
                list_data.colour  <= rd_byte[7:4];
            end
            3'd4: begin
                list_data.x <= {list_data.x[8], rd_byte} - `TC_X_BIAS;
            end
            default: begin
            end
        endcase
    end

endmodule

`default_nettype wire

// File: sprite_video_top.sv
/*
 * Top of the sprite and colour path. Connects the download decoder, the
 * sprite list copy, the line renderer, the mixer and their two tables.
 */
`default_nettype none
`timescale 1ns/1ps
`include "tc_params.svh"

module sprite_video_top (
    input  wire                    clk_sys,
    input  wire                    reset,
    input  wire                    dl_active,
    input  wire [7:0]              dl_index,
    input  wire                    dl_wr,
    input  wire [24:0]             dl_addr,
    input  wire [7:0]              dl_data,
    input  wire                    spr_wr,
    input  wire [7:0]              spr_addr,
    input  wire [7:0]              spr_data,
    input  wire                    vblank,
    input  wire                    ce_pix,
    input  wire [8:0]              hcount,
    input  wire [8:0]              vcount,
    input  wire [3:0]              fg_pix,
    input  wire tc_pkg::pal_idx_t  bg_pix,
    input  wire                    bg_off,
    output tc_pkg::rgb_t           rgb
);

    import tc_pkg::*;

    logic       dl_busy;
    logic       gfx_wr;
    logic       prom_r_wr;
    logic       prom_g_wr;
    logic       prom_b_wr;
    logic       prom_s_wr;
    logic       prom_u_wr;
    logic       list_wr;
    logic [5:0] list_wr_addr;
    spr_attr_t  list_wr_data;
    logic [5:0] list_rd_addr;
    spr_attr_t  list_rd_data;
    logic       line_wr;
    logic [7:0] line_addr;
    spr_pix_t   line_data;
    spr_pix_t   spr_pix;

    // ==============================
    // download and sprite list
    // ==============================
    rom_loader u_rom_loader (
        .clk_sys   (clk_sys),
        .dl_active (dl_active),
        .dl_index  (dl_index),
        .dl_wr     (dl_wr),
        .dl_addr   (dl_addr),
        .busy      (dl_busy),
        .gfx_wr    (gfx_wr),
        .prom_r_wr (prom_r_wr),
        .prom_g_wr (prom_g_wr),
        .prom_b_wr (prom_b_wr),
        .prom_s_wr (prom_s_wr),
        .prom_u_wr (prom_u_wr)
    );

    sprite_list_copy u_list_copy (
        .clk_sys   (clk_sys),
        .reset     (reset),
        .spr_wr    (spr_wr),
        .spr_addr  (spr_addr),
        .spr_data  (spr_data),
        .vblank    (vblank),
        .list_wr   (list_wr),
        .list_addr (list_wr_addr),
        .list_data (list_wr_data)
    );

    dp_table #(
        .DEPTH     (`TC_SPRITES),
        .payload_t (spr_attr_t)
    ) sprite_list (
        .clk_sys (clk_sys),
        .wr      (list_wr),
        .wr_addr (list_wr_addr),
        .wr_data (list_wr_data),
        .rd_addr (list_rd_addr),
        .rd_data (list_rd_data)
    );

    // ==============================
    // line render and mixing
    // ==============================
    sprite_line_render u_render (
        .clk_sys   (clk_sys),
        .reset     (reset),
        .busy      (dl_busy),
        .hcount    (hcount),
        .vcount    (vcount),
        .dl_addr   (dl_addr),
        .dl_data   (dl_data),
        .gfx_wr    (gfx_wr),
        .prom_u_wr (prom_u_wr),
        .list_addr (list_rd_addr),
        .list_data (list_rd_data),
        .line_wr   (line_wr),
        .line_addr (line_addr),
        .line_data (line_data)
    );

    // display side reads at the current pixel column
    dp_table #(
        .DEPTH     (`TC_LINE_W),
        .payload_t (spr_pix_t)
    ) line_buffer (
        .clk_sys (clk_sys),
        .wr      (line_wr),
        .wr_addr (line_addr),
        .wr_data (line_data),
        .rd_addr (hcount[7:0]),
        .rd_data (spr_pix)
    );

    pixel_mixer u_mixer (
        .clk_sys   (clk_sys),
        .reset     (reset),
        .ce_pix    (ce_pix),
        .dl_addr   (dl_addr),
        .dl_data   (dl_data),
        .prom_r_wr (prom_r_wr),
        .prom_g_wr (prom_g_wr),
        .prom_b_wr (prom_b_wr),
        .prom_s_wr (prom_s_wr),
        .fg_pix    (fg_pix),
        .bg_pix    (bg_pix),
        .bg_off    (bg_off),
        .spr_pix   (spr_pix),
        .rgb       (rgb)
    );

endmodule

`default_nettype wire

// File: src.f
+incdir+.
tc_pkg.sv
dp_table.sv
rom_loader.sv
sprite_list_copy.sv
sprite_line_render.sv
pixel_mixer.sv
sprite_video_top.sv
tb_top.sv

// File: tb_ref.svh
/*
 * Reference model for the sprite video testbench. Holds shadow copies of the
 * downloaded ROMs and of the sprite RAM, and computes the expected colour.
 */
`ifndef TB_REF_SVH
`define TB_REF_SVH

logic [7:0] gfx_sh [65536];
// PROM shadows in download order: red, green, blue, sprite colour, bank
logic [3:0] prom_sh [5][256];
logic [7:0] spr_sh [256];
// sprite RAM as it stood at the last vblank rise
logic [7:0] list_sh [256];

// sprite pixel at one column, zero where no opaque pen lands
function automatic spr_pix_t ref_sprite(input logic [7:0] line, input logic [7:0] col);
    spr_pix_t   pix;
    logic [7:0] y;
    logic [8:0] tile;
    logic [8:0] x;
    logic [8:0] o9;
    logic [3:0] r;
    logic [3:0] fx;
    logic [3:0] fy;
    logic [7:0] gbyte;
    logic [3:0] pen;
    pix = '0;
    for (int i = 0; i < 64; i++) begin
        y    = 8'd240 - list_sh[4*i];
        tile = {list_sh[4*i+2][1], list_sh[4*i+1]};
        x    = {list_sh[4*i+2][0], list_sh[4*i+3]} - 9'd128;
        o9   = {1'b0, col} - x;
        if (({1'b0, line} >= {1'b0, y}) && ({1'b0, line} < {1'b0, y} + 9'd16)
            && (x < 9'd256) && ({1'b0, col} >= x) && (o9 < 9'd16)) begin
            r     = 4'(line - y);
            fx    = list_sh[4*i+2][2] ? 4'd15 - o9[3:0] : o9[3:0];
            fy    = list_sh[4*i+2][3] ? 4'd15 - r : r;
            gbyte = gfx_sh[{fx[1], tile, fy, fx[3:2]}];
            pen   = fx[0] ? gbyte[7:4] : gbyte[3:0];
            // later entries paint over earlier ones
            if (pen != 4'd0) begin
                pix = '{bank: prom_sh[4][tile[8:1]], colour: list_sh[4*i+2][7:4], pen: pen};
            end
        end
    end
    return pix;
endfunction

// expected output colour for one sampled pixel
function automatic rgb_t ref_rgb(input logic [7:0] line, input logic [7:0] col,
                                 input logic [3:0] fg, input pal_idx_t bg,
                                 input logic bg_off);
    spr_pix_t   sp;
    logic [1:0] bank2;
    pal_idx_t   idx;
    sp    = ref_sprite(line, col);
    bank2 = sp.pen[3] ? sp.bank[3:2] : sp.bank[1:0];
    if (fg < 4'd15) begin
        idx = {4'b0000, fg};
    end else if ((sp == '0) && !bg_off) begin
        idx = bg;
    end else begin
        idx = {2'b10, bank2, prom_sh[3][{sp.colour, sp.pen}]};
    end
    return '{r: prom_sh[0][idx], g: prom_sh[1][idx], b: prom_sh[2][idx]};
endfunction

`endif

// File: tb_top.sv
/*
 * Testbench for the sprite video top. Downloads random ROM data, places
 * sprites through the CPU port, renders lines and checks each swept pixel.
 */
`default_nettype none
`timescale 1ns/1ps

module tb_top;

    import tc_pkg::*;

    localparam int N_LINES      = 13;
    localparam int DL_CYCLES    = 65536 + 5 * 256;
    localparam int LINE_CYCLES  = 500 + 3000 + 256 * 4 + 64;
    localparam int SETUP_CYCLES = 4 * 512 + 64;
    localparam int LIMIT_CYCLES = DL_CYCLES + N_LINES * LINE_CYCLES + SETUP_CYCLES + 20000;

    logic        clk_sys;
    logic        reset;
    logic        dl_active;
    logic [7:0]  dl_index;
    logic        dl_wr;
    logic [24:0] dl_addr;
    logic [7:0]  dl_data;
    logic        spr_wr;
    logic [7:0]  spr_addr;
    logic [7:0]  spr_data;
    logic        vblank;
    logic        ce_pix;
    logic [8:0]  hcount;
    logic [8:0]  vcount;
    logic [3:0]  fg_pix;
    pal_idx_t    bg_pix;
    logic        bg_off;
    rgb_t        rgb;
    logic [1:0]  ce_cnt;
    logic        sweeping;
    int          errors;
    int          checks;
    // one entry per ce_pix holding valid bit, line, column and expected colour
    logic [28:0] pipe_q [$];

    `include "tb_ref.svh"

    sprite_video_top uut (
        .clk_sys(clk_sys), .reset(reset),
        .dl_active(dl_active), .dl_index(dl_index), .dl_wr(dl_wr),
        .dl_addr(dl_addr), .dl_data(dl_data),
        .spr_wr(spr_wr), .spr_addr(spr_addr), .spr_data(spr_data),
        .vblank(vblank), .ce_pix(ce_pix), .hcount(hcount), .vcount(vcount),
        .fg_pix(fg_pix), .bg_pix(bg_pix), .bg_off(bg_off), .rgb(rgb)
    );

    always #5 clk_sys = ~clk_sys;

    // pixel enable every fourth cycle
    always @(posedge clk_sys) begin
        ce_cnt <= ce_cnt + 2'd1;
        ce_pix <= (ce_cnt == 2'd3);
    end

    // ==============================
    // compare three ce_pix behind the sample
    // ==============================
    always @(posedge clk_sys) begin
        logic [28:0] entry;
        if (ce_pix) begin
            if (pipe_q.size() == 3) begin
                entry = pipe_q.pop_front();
                if (entry[28]) begin
                    checks++;
                    if (rgb !== entry[11:0]) begin
                        errors++;
                        $display("CHECK FAILED rgb line %0d col %0d: expected %h, got %h",
                                 entry[27:20], entry[19:12], entry[11:0], rgb);
                    end
                end
            end
            if (sweeping) begin
                pipe_q.push_back({1'b1, vcount[7:0], hcount[7:0],
                                  ref_rgb(vcount[7:0], hcount[7:0], fg_pix, bg_pix, bg_off)});
            end else begin
                pipe_q.push_back('0);
            end
        end
    end

    task automatic wait_ce();
        @(posedge clk_sys);
        while (!ce_pix) begin
            @(posedge clk_sys);
        end
    endtask

    task automatic download_byte(input logic [24:0] addr, input logic [7:0] data);
        @(posedge clk_sys);
        dl_wr   <= 1'b1;
        dl_addr <= addr;
        dl_data <= data;
    endtask

    task automatic load_roms();
        logic [7:0] data;
        @(posedge clk_sys);
        dl_active <= 1'b1;
        dl_index  <= 8'd0;
        for (int a = 0; a < 65536; a++) begin
            data      = 8'($urandom);
            gfx_sh[a] = data;
            download_byte(25'h050000 + 25'(a), data);
        end
        for (int p = 0; p < 5; p++) begin
            for (int a = 0; a < 256; a++) begin
                data          = 8'($urandom);
                prom_sh[p][a] = data[3:0];
                download_byte(25'h07E000 + 25'(p * 256 + a), data);
            end
        end
        @(posedge clk_sys);
        dl_wr     <= 1'b0;
        dl_active <= 1'b0;
    endtask

    task automatic write_spr(input logic [7:0] addr, input logic [7:0] data);
        @(posedge clk_sys);
        spr_wr   <= 1'b1;
        spr_addr <= addr;
        spr_data <= data;
        @(posedge clk_sys);
        spr_wr       <= 1'b0;
        spr_sh[addr]  = data;
    endtask

    // all-zero bytes put every sprite off screen at X 384
    task automatic clear_sprites();
        for (int a = 0; a < 256; a++) begin
            write_spr(8'(a), 8'd0);
        end
    endtask

    task automatic place_sprite(input logic [5:0] idx, input logic [7:0] y,
                                input logic [8:0] tile, input logic [8:0] x,
                                input logic [3:0] colour, input logic flip_x,
                                input logic flip_y);
        logic [8:0] xraw;
        xraw = x + 9'd128;
        write_spr({idx, 2'd0}, 8'd240 - y);
        write_spr({idx, 2'd1}, tile[7:0]);
        write_spr({idx, 2'd2}, {colour, flip_y, flip_x, tile[8], xraw[8]});
        write_spr({idx, 2'd3}, xraw[7:0]);
    endtask

    // optional copy, render in the blank, then sweep the visible line
    task automatic run_line(input logic [7:0] line, input logic do_vblank,
                            input logic fg_low, input logic bgoff);
        if (do_vblank) begin
            @(posedge clk_sys);
            vblank  <= 1'b1;
            list_sh  = spr_sh;
            repeat (500) @(posedge clk_sys);
            vblank <= 1'b0;
        end
        wait_ce();
        vcount <= 9'(line) - 9'd1;
        hcount <= 9'd300;
        repeat (3000) @(posedge clk_sys);
        for (int h = 0; h < 256; h++) begin
            wait_ce();
            hcount   <= 9'(h);
            vcount   <= {1'b0, line};
            fg_pix   <= fg_low ? 4'($urandom_range(14)) : 4'd15;
            bg_pix   <= 8'($urandom);
            bg_off   <= bgoff;
            sweeping <= 1'b1;
        end
        wait_ce();
        sweeping <= 1'b0;
        repeat (4) wait_ce();
    endtask

    // ==============================
    // test sequence
    // ==============================
    initial begin
        logic [7:0]  y;
        logic [8:0]  tile;
        logic [8:0]  x;
        clk_sys   = 1'b0;
        reset     = 1'b1;
        dl_active = 1'b0;
        dl_index  = 8'd0;
        dl_wr     = 1'b0;
        dl_addr   = '0;
        dl_data   = '0;
        spr_wr    = 1'b0;
        spr_addr  = '0;
        spr_data  = '0;
        vblank    = 1'b0;
        ce_pix    = 1'b0;
        ce_cnt    = '0;
        hcount    = '0;
        vcount    = '0;
        fg_pix    = '0;
        bg_pix    = '0;
        bg_off    = 1'b0;
        sweeping  = 1'b0;
        errors    = 0;
        checks    = 0;
        void'($urandom(32'h2eef));
        repeat (3) @(posedge clk_sys);
        reset <= 1'b0;
        if (rgb !== 12'h000) begin
            errors++;
            $display("CHECK FAILED rgb after reset: expected %h, got %h", 12'h000, rgb);
        end
        load_roms();
        clear_sprites();

        // foreground wins, then background with no sprites
        run_line(8'd40, 1'b1, 1'b1, 1'b0);
        run_line(8'd41, 1'b0, 1'b0, 1'b0);

        // one sprite anywhere, then one clipped at the right edge
        y    = 8'd60 - 8'($urandom_range(15));
        tile = 9'($urandom);
        place_sprite(6'd5, y, tile, 9'($urandom_range(255)), 4'($urandom), 1'b0, 1'b0);
        run_line(8'd60, 1'b1, 1'b0, 1'b0);
        y = 8'd100 - 8'($urandom_range(15));
        x = 9'(241 + $urandom_range(14));
        place_sprite(6'd5, y, tile, x, 4'($urandom), 1'b0, 1'b0);
        run_line(8'd100, 1'b1, 1'b0, 1'b0);

        // flip combinations with X on both sides of the high bit
        for (int f = 0; f < 4; f++) begin
            y = 8'd120 - 8'($urandom_range(15));
            x = f[0] ? 9'(128 + $urandom_range(127)) : 9'($urandom_range(127));
            place_sprite(6'd5, y, 9'($urandom), x, 4'($urandom), f[0], f[1]);
            run_line(8'd120, 1'b1, 1'b0, 1'b0);
        end

        // overlap with the higher index on top, then with the background off
        clear_sprites();
        x = 9'($urandom_range(230));
        place_sprite(6'd10, 8'd150 - 8'($urandom_range(15)), 9'($urandom), x,
                     4'($urandom), 1'b0, 1'b0);
        place_sprite(6'd20, 8'd150 - 8'($urandom_range(15)), 9'($urandom),
                     x + 9'($urandom_range(8)), 4'($urandom), 1'b1, 1'b0);
        run_line(8'd150, 1'b1, 1'b0, 1'b0);
        run_line(8'd150, 1'b0, 1'b0, 1'b1);

        // CPU rewrite reaches the list only at the next vblank rise
        clear_sprites();
        place_sprite(6'd30, 8'd200 - 8'($urandom_range(15)), 9'($urandom),
                     9'($urandom_range(120)), 4'($urandom), 1'b0, 1'b1);
        run_line(8'd200, 1'b1, 1'b0, 1'b0);
        place_sprite(6'd30, 8'd200 - 8'($urandom_range(15)), 9'($urandom),
                     9'(128 + $urandom_range(120)), 4'($urandom), 1'b1, 1'b1);
        place_sprite(6'd31, 8'd200 - 8'($urandom_range(15)), 9'($urandom),
                     9'($urandom_range(240)), 4'($urandom), 1'b0, 1'b0);
        run_line(8'd200, 1'b0, 1'b0, 1'b0);
        run_line(8'd200, 1'b1, 1'b0, 1'b0);

        if (checks != N_LINES * 256) begin
            errors++;
            $display("only %0d of %0d pixels were checked", checks, N_LINES * 256);
        end
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

    // watchdog
    initial begin
        #(LIMIT_CYCLES * 10);
        $display("timeout: run did not finish within %0d cycles, %0d errors so far",
                 LIMIT_CYCLES, errors);
        $display("=== FAIL ===");
        $finish;
    end

endmodule

`default_nettype wire

// File: tc_params.svh
/*
 * Board constants for the sprite and colour path. Include this file in any
 * module that sizes the sprite list or line buffer or decodes the download map.
 */
`ifndef TC_PARAMS_SVH
`define TC_PARAMS_SVH

// sprite list and line geometry
`define TC_SPRITES    64
`define TC_LINE_W     256
`define TC_SPR_SIZE   16

// coordinate decode of the sprite RAM bytes
`define TC_Y_BASE     8'd240
`define TC_X_BIAS     9'd128

// download map, all ROMs come in on one index
`define TC_ROM_INDEX  8'd0
`define TC_GFX_BASE   25'h050000
`define TC_GFX_END    25'h05FFFF
`define TC_PROM_R     25'h07E000
`define TC_PROM_G     25'h07E100
`define TC_PROM_B     25'h07E200
`define TC_PROM_S     25'h07E300
`define TC_PROM_U     25'h07E400

`endif

// File: tc_pkg.sv
/*
 * Shared types of the sprite and colour path: decoded sprite entries,
 * line-buffer pixels, palette indices and output colour.
 */
`default_nettype none

package tc_pkg;

    // one decoded sprite list entry
    typedef struct packed {
        logic [8:0] tile;
        logic [8:0] x;
        logic [7:0] y;
        logic [3:0] colour;
        logic       flip_x;
        logic       flip_y;
    } spr_attr_t;

    // line buffer entry, all zero means no sprite
    typedef struct packed {
        logic [3:0] bank;
        logic [3:0] colour;
        logic [3:0] pen;
    } spr_pix_t;

    typedef logic [7:0] pal_idx_t;

    typedef struct packed {
        logic [3:0] r;
        logic [3:0] g;
        logic [3:0] b;
    } rgb_t;

endpackage

`default_nettype wire
